// File: rtl/keypad_pkg.sv
//////////////////////////////////////////////////////////////////////
// Keypad package
// Key codes, multi-tap states, scan timing and the word record
//////////////////////////////////////////////////////////////////////
package keypad_pkg;

    // Scan and debounce timing
    localparam int SCAN_CYCLES    = 4;  // Clocks each row is driven
    localparam int DEBOUNCE_SCANS = 3;  // Agreeing full scans for press or release
    localparam int MAX_WORD_LEN   = 8;  // Letters per word

    typedef logic [$clog2(SCAN_CYCLES)-1:0]    scan_cnt_t;
    typedef logic [$clog2(DEBOUNCE_SCANS)-1:0] deb_cnt_t;

    localparam scan_cnt_t SCAN_LAST = scan_cnt_t'(SCAN_CYCLES - 1);    // Sample cycle
    localparam deb_cnt_t  DEB_LAST  = deb_cnt_t'(DEBOUNCE_SCANS - 1);

    typedef logic [7:0] key_code_t;   // {row one-hot, column one-hot}
    typedef logic [7:0] ascii_t;      // Upper case letter, 0 when none
    typedef logic [3:0] word_len_t;   // 0 to MAX_WORD_LEN

    // Tap index of the pending letter, INIT when nothing is pending
    typedef enum logic [2:0] {
        INIT,
        S0,
        S1,
        S2,
        S3
    } tap_state_t;

    // Bit 3 of each nibble is R0 or C0, bit 0 is R3 or C3
    localparam key_code_t NO_KEY = 8'b0000_0000;
    localparam key_code_t KEY_1  = 8'b1000_1000;  // R0 C0, no letters
    localparam key_code_t KEY_2  = 8'b1000_0100;  // R0 C1
    localparam key_code_t KEY_3  = 8'b1000_0010;  // R0 C2
    localparam key_code_t KEY_4  = 8'b0100_1000;  // R1 C0
    localparam key_code_t KEY_5  = 8'b0100_0100;  // R1 C1
    localparam key_code_t KEY_6  = 8'b0100_0010;  // R1 C2
    localparam key_code_t KEY_7  = 8'b0010_1000;  // R2 C0, four letters
    localparam key_code_t KEY_8  = 8'b0010_0100;  // R2 C1
    localparam key_code_t KEY_9  = 8'b0010_0010;  // R2 C2, four letters

    // Control keys on the bottom row
    localparam key_code_t KEY_SUBMIT_LETTER = 8'b0001_1000;  // R3 C0
    localparam key_code_t KEY_CLEAR         = 8'b0001_0100;  // R3 C1
    localparam key_code_t KEY_SUBMIT_WORD   = 8'b0001_0010;  // R3 C2

    localparam logic [3:0] COL_INVALID = 4'b0001;  // C3, whole column ignored

    // Word handed out on submit
    typedef struct packed {
        ascii_t [MAX_WORD_LEN-1:0] letters;  // Letter 0 in the low byte
        word_len_t                 len;      // Number of valid letters
    } word_t;

endpackage

// File: rtl/key_scanner.sv
//////////////////////////////////////////////////////////////////////
// Key scanner
// Drives the rows, samples the columns and debounces to one strobe per press
//////////////////////////////////////////////////////////////////////
module key_scanner (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic [3:0]            cols,
    output logic [3:0]            rows,
    output logic                  key_strobe,
    output keypad_pkg::key_code_t key
);
    import keypad_pkg::*;

    scan_cnt_t cyc_cnt;       // Position inside the row period
    logic      row_last;      // Last cycle of a row period
    logic      scan_end;      // Last cycle of a full scan
    key_code_t sample_code;   // Code seen on the current row
    key_code_t scan_code;     // First code captured in this scan
    key_code_t this_scan;     // Code of the scan that ends now
    key_code_t cand_code;     // Code being debounced
    deb_cnt_t  deb_cnt;       // Agreeing scans so far
    logic      pressed;       // Released/pressed flag
    logic      press_accept;

    // Lowest column number wins if more than one is active
    function automatic logic [3:0] first_col(logic [3:0] c);
        casez (c)
            4'b1???: return 4'b1000;  // C0
            4'b01??: return 4'b0100;
            4'b001?: return 4'b0010;
            4'b0001: return 4'b0001;  // C3
            default: return 4'b0000;
        endcase
    endfunction

    assign row_last    = (cyc_cnt == SCAN_LAST);
    assign scan_end    = row_last && rows[3];  // R0 is the last row of a scan
    assign sample_code = (cols != 4'b0000) ? {rows, first_col(cols)} : NO_KEY;
    assign this_scan   = (scan_code != NO_KEY) ? scan_code : sample_code;

    // Third matching scan while released
    assign press_accept = scan_end && !pressed && (this_scan != NO_KEY) &&
                          (this_scan == cand_code) && (deb_cnt == DEB_LAST);

    // Row driver, one row every SCAN_CYCLES clocks
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cyc_cnt <= '0;
            rows    <= 4'b0001;
        end else if (row_last) begin
            cyc_cnt <= '0;
            rows    <= {rows[2:0], rows[3]};  // Rotate and wrap
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // Holds the first hit until the scan ends
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            scan_code <= NO_KEY;
        end else if (scan_end) begin
            scan_code <= NO_KEY;                 // Start the next scan empty
        end else if (row_last && (scan_code == NO_KEY)) begin
            scan_code <= sample_code;
        end
    end

    // Debounce on whole scans
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cand_code  <= NO_KEY;
            deb_cnt    <= '0;
            pressed    <= 1'b0;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= press_accept;
            if (scan_end && !pressed) begin
                if (this_scan == NO_KEY) begin
                    cand_code <= NO_KEY;
                    deb_cnt   <= '0;
                end else if (this_scan != cand_code) begin
                    cand_code <= this_scan;      // New candidate, first scan seen
                    deb_cnt   <= deb_cnt_t'(1);
                end else if (press_accept) begin
                    pressed <= 1'b1;
                    deb_cnt <= '0;               // Reused for the release count
                end else begin
                    deb_cnt <= deb_cnt + 1'b1;
                end
            end else if (scan_end) begin
                if (this_scan != NO_KEY) begin
                    deb_cnt <= '0;               // Still held
                end else if (deb_cnt == DEB_LAST) begin
                    pressed   <= 1'b0;
                    deb_cnt   <= '0;
                    cand_code <= NO_KEY;
                end else begin
                    deb_cnt <= deb_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (press_accept) key <= this_scan;  // Valid with key_strobe
    end

    a_rows_onehot: assert property (@(posedge clk) disable iff (!nRst) $onehot(rows));

    // One strobe per press, never stretched
    a_strobe_single: assert property (@(posedge clk) disable iff (!nRst)
        key_strobe |=> !key_strobe);

endmodule

// File: rtl/keypad_fsm.sv
//////////////////////////////////////////////////////////////////////
// Multi-tap letter FSM
// Turns repeated taps into a letter preview and decodes the control keys
//////////////////////////////////////////////////////////////////////
module keypad_fsm (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  key_strobe,
    input  keypad_pkg::key_code_t key,
    output logic                  letter_valid,
    output keypad_pkg::ascii_t    letter,
    output keypad_pkg::ascii_t    preview,
    output logic                  clear,
    output logic                  submit
);
    import keypad_pkg::*;

    tap_state_t state;
    tap_state_t next_state;
    key_code_t  prev_key;       // Last letter key tapped
    key_code_t  next_prev_key;
    logic       letter_key;     // Strobed key is one of 2 to 9
    logic       ignore_key;
    logic       do_letter;
    logic       do_clear;
    logic       do_submit;

    // First letter on each key, 0 for everything else
    function automatic ascii_t base_letter(key_code_t k);
        case (k)
            KEY_2:   return 8'h41;  // A
            KEY_3:   return 8'h44;  // D
            KEY_4:   return 8'h47;  // G
            KEY_5:   return 8'h4A;  // J
            KEY_6:   return 8'h4D;  // M
            KEY_7:   return 8'h50;  // P
            KEY_8:   return 8'h54;  // T
            KEY_9:   return 8'h57;  // W
            default: return 8'h00;
        endcase
    endfunction

    function automatic ascii_t tap_index(tap_state_t s);
        case (s)
            S1:      return 8'd1;
            S2:      return 8'd2;
            S3:      return 8'd3;
            default: return 8'd0;  // S0, INIT never previewed
        endcase
    endfunction

    assign letter_key = (base_letter(key) != 8'h00);

    // KEY_1, column C3, or submit with nothing pending
    assign ignore_key = (key == KEY_1) || (key[3:0] == COL_INVALID) ||
                        ((key == KEY_SUBMIT_LETTER) && (state == INIT));

    always_comb begin
        next_state    = state;
        next_prev_key = prev_key;
        do_letter     = 1'b0;
        do_clear      = 1'b0;
        do_submit     = 1'b0;
        if (key_strobe && !ignore_key) begin
            if (key == KEY_CLEAR) begin
                next_state = INIT;          // Pending letter dropped
                do_clear   = 1'b1;
            end else if (key == KEY_SUBMIT_WORD) begin
                next_state = INIT;
                do_submit  = 1'b1;
            end else if (key == KEY_SUBMIT_LETTER) begin
                next_state = INIT;          // Commit the preview
                do_letter  = 1'b1;
            end else if (letter_key) begin
                next_prev_key = key;
                if ((state == INIT) || (key != prev_key)) begin
                    next_state = S0;        // First tap, or another key
                end else begin
                    case (state)
                        S0:      next_state = S1;
                        S1:      next_state = S2;
                        S2:      next_state = ((key == KEY_7) || (key == KEY_9)) ? S3 : S0;
                        default: next_state = S0;  // S3 wraps
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= INIT;
            prev_key     <= NO_KEY;
            preview      <= '0;
            letter_valid <= 1'b0;
            clear        <= 1'b0;
            submit       <= 1'b0;
        end else begin
            state        <= next_state;
            prev_key     <= next_prev_key;
            letter_valid <= do_letter;
            clear        <= do_clear;
            submit       <= do_submit;
            // Preview follows the new state in the same cycle as the pulses
            if (next_state == INIT) begin
                preview <= '0;
            end else begin
                preview <= base_letter(next_prev_key) + tap_index(next_state);
            end
        end
    end

    // Old preview is the committed letter
    always_ff @(posedge clk) begin
        if (do_letter) letter <= preview;
    end

    a_one_pulse: assert property (@(posedge clk) disable iff (!nRst)
        $onehot0({letter_valid, clear, submit}));

endmodule

// File: rtl/word_buffer.sv
//////////////////////////////////////////////////////////////////////
// Word buffer
// Collects committed letters and hands out the word on submit
//////////////////////////////////////////////////////////////////////
module word_buffer (
    input  logic               clk,
    input  logic               nRst,
    input  logic               letter_valid,
    input  keypad_pkg::ascii_t letter,
    input  logic               clear,
    input  logic               submit,
    output logic               word_valid,
    output keypad_pkg::word_t  word
);
    import keypad_pkg::*;

    ascii_t [MAX_WORD_LEN-1:0] letters;  // Collected letters with unused slots at 0
    word_len_t                 len;
    logic                      room;     // Space for another letter

    assign room = (len < word_len_t'(MAX_WORD_LEN));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            letters    <= '0;
            len        <= '0;
            word_valid <= 1'b0;
            word       <= '0;
        end else begin
            word_valid <= 1'b0;
            if (clear) begin
                letters <= '0;
                len     <= '0;
                word    <= '0;
            end else if (submit) begin
                word.letters <= letters;   // Empty word allowed
                word.len     <= len;
                word_valid   <= 1'b1;
                letters      <= '0;
                len          <= '0;
            end else if (letter_valid && room) begin
                for (int i = 0; i < MAX_WORD_LEN; i++) begin
                    if (len == word_len_t'(i)) letters[i] <= letter;  // Append at len
                end
                len <= len + 1'b1;
            end
            // Letters past MAX_WORD_LEN fall through here and are lost
        end
    end

    a_len_max: assert property (@(posedge clk) disable iff (!nRst)
        (len <= word_len_t'(MAX_WORD_LEN)) && (word.len <= word_len_t'(MAX_WORD_LEN)));

endmodule

// File: rtl/keypad_top.sv
//////////////////////////////////////////////////////////////////////
// Keypad text entry top
// Scanner, multi-tap FSM and word buffer in one chain
//////////////////////////////////////////////////////////////////////
module keypad_top (
    input  logic               clk,
    input  logic               nRst,
    input  logic [3:0]         cols,
    output logic [3:0]         rows,
    output keypad_pkg::ascii_t preview,
    output logic               word_valid,
    output keypad_pkg::word_t  word
);
    import keypad_pkg::*;

    logic      key_strobe;    // One pulse per debounced press
    key_code_t key;
    logic      letter_valid;  // Committed letter
    ascii_t    letter;
    logic      clear;
    logic      submit;

    key_scanner u_scanner (
        .clk        (clk),
        .nRst       (nRst),
        .cols       (cols),
        .rows       (rows),
        .key_strobe (key_strobe),
        .key        (key)
    );

    keypad_fsm u_fsm (
        .clk          (clk),
        .nRst         (nRst),
        .key_strobe   (key_strobe),
        .key          (key),
        .letter_valid (letter_valid),
        .letter       (letter),
        .preview      (preview),
        .clear        (clear),
        .submit       (submit)
    );

    word_buffer u_word (
        .clk          (clk),
        .nRst         (nRst),
        .letter_valid (letter_valid),
        .letter       (letter),
        .clear        (clear),
        .submit       (submit),
        .word_valid   (word_valid),
        .word         (word)
    );

endmodule

// File: dv/keypad_tb.sv
//////////////////////////////////////////////////////////////////////
// Keypad text entry testbench
// Keypad matrix model, multi-tap reference model and word checker
//////////////////////////////////////////////////////////////////////
module keypad_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import keypad_pkg::*;

    localparam int HOLD_CYCLES  = 200;    // Per press and per release
    localparam int WORD_TIMEOUT = 60000;  // Longest gap between two words
    localparam int DRAIN_CYCLES = 50;

    logic        clk;
    logic        nRst;
    logic [3:0]  cols;
    logic [3:0]  rows;
    ascii_t      preview;
    logic        word_valid;
    word_t       word;

    key_code_t   held;        // Key under the finger or NO_KEY when up
    ascii_t      model_q[$];  // Committed since the last submit or clear
    word_t       exp_q[$];    // Words still owed by the DUT
    string       test_name;
    int unsigned lcg_state;

    keypad_top u_dut (
        .clk        (clk),
        .nRst       (nRst),
        .cols       (cols),
        .rows       (rows),
        .preview    (preview),
        .word_valid (word_valid),
        .word       (word)
    );

    // Pressed key shorts its row line to its column line
    assign cols = ((rows & held[7:4]) != 4'b0000) ? held[3:0] : 4'b0000;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
            fail_run();
        end
    endtask

    function automatic int unsigned rand_below(int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;  // Low bits of an LCG are weak
    endfunction

    // Letter keys 2 to 9 as index 0 to 7
    function automatic key_code_t key_of(int idx);
        case (idx)
            0:       return KEY_2;
            1:       return KEY_3;
            2:       return KEY_4;
            3:       return KEY_5;
            4:       return KEY_6;
            5:       return KEY_7;
            6:       return KEY_8;
            default: return KEY_9;
        endcase
    endfunction

    // Expected letter after a run of taps on one key
    function automatic ascii_t ref_letter(int idx, int taps);
        ascii_t base;
        int     span;
        case (idx)
            0:       base = "A";
            1:       base = "D";
            2:       base = "G";
            3:       base = "J";
            4:       base = "M";
            5:       base = "P";
            6:       base = "T";
            default: base = "W";
        endcase
        span = ((idx == 5) || (idx == 7)) ? 4 : 3;  // PQRS and WXYZ
        return base + ascii_t'((taps - 1) % span);
    endfunction

    task automatic press_key(key_code_t k);
        @(negedge clk);
        held = k;
        repeat (HOLD_CYCLES) @(negedge clk);
        held = NO_KEY;
        repeat (HOLD_CYCLES) @(negedge clk);  // Long enough for release debounce
    endtask

    task automatic tap_key(int idx, int taps);
        for (int t = 1; t <= taps; t++) begin
            press_key(key_of(idx));
            check_value("preview", ref_letter(idx, t), preview);
        end
    endtask

    task automatic commit_letter(ascii_t expected);
        press_key(KEY_SUBMIT_LETTER);
        check_value("preview after commit", 8'h00, preview);
        model_q.push_back(expected);
    endtask

    task automatic enter_letter(int idx, int taps);
        tap_key(idx, taps);
        commit_letter(ref_letter(idx, taps));
    endtask

    task automatic clear_entry();
        press_key(KEY_CLEAR);
        check_value("preview after clear", 8'h00, preview);
        model_q.delete();
    endtask

    task automatic submit_word();
        word_t exp;
        int    n;
        int    waited;
        exp = '0;
        n   = (model_q.size() < MAX_WORD_LEN) ? model_q.size() : MAX_WORD_LEN;
        for (int i = 0; i < n; i++) begin
            exp.letters[i] = model_q[i];  // Anything past capacity is dropped
        end
        exp.len = word_len_t'(n);
        model_q.delete();
        exp_q.push_back(exp);
        press_key(KEY_SUBMIT_WORD);
        check_value("preview after submit", 8'h00, preview);
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_CYCLES) begin
                $display("Timeout: submitted word never came out");
                fail_run();
            end
        end
    endtask

    // Word checker sampling away from the rising edge
    initial begin : monitor
        word_t exp;
        int    waited;
        forever begin
            waited = 0;
            while (word_valid !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > WORD_TIMEOUT) begin
                    $display("Timeout: no word_valid pulse seen");
                    fail_run();
                end
            end
            if (exp_q.size() == 0) begin
                $display("word_valid pulsed while no word was expected");
                fail_run();
            end
            exp = exp_q.pop_front();
            check_value("word len", exp.len, word.len);
            for (int i = 0; i < MAX_WORD_LEN; i++) begin
                check_value($sformatf("letter %0d", i), exp.letters[i], word.letters[i]);
            end
            @(negedge clk);  // Past the one-cycle pulse
        end
    end

    initial begin
        int n_letters;
        int idx;
        int taps;
        nRst      = 1'b0;
        held      = NO_KEY;
        lcg_state = 54760;
        test_name = "reset";
        repeat (10) @(negedge clk);
        nRst = 1'b1;
        check_value("rows", 4'b0001, rows);
        check_value("preview", 8'h00, preview);
        check_value("word len", 0, word.len);

        test_name = "single_taps";  // ADW
        enter_letter(0, 1);
        enter_letter(1, 1);
        enter_letter(7, 1);
        submit_word();

        test_name = "multi_tap_wrap";  // ASPY
        enter_letter(0, 4);
        enter_letter(5, 4);
        enter_letter(5, 5);
        enter_letter(7, 3);
        submit_word();

        test_name = "clear_discard";
        enter_letter(2, 1);
        enter_letter(3, 2);
        clear_entry();           // G and K gone
        tap_key(4, 2);           // N pending
        enter_letter(6, 3);      // Other key drops N
        tap_key(1, 1);
        clear_entry();           // Pending D dropped too
        enter_letter(0, 2);
        submit_word();           // VB

        test_name = "ignored_keys";
        press_key(KEY_SUBMIT_LETTER);  // Nothing pending
        check_value("preview", 8'h00, preview);
        press_key(KEY_1);
        check_value("preview", 8'h00, preview);
        tap_key(2, 1);
        press_key(KEY_1);
        check_value("preview", ref_letter(2, 1), preview);
        for (int r = 0; r < 4; r++) begin
            press_key(key_code_t'({4'b1000 >> r, COL_INVALID}));  // Whole C3 column
            check_value("preview", ref_letter(2, 1), preview);
        end
        commit_letter(ref_letter(2, 1));
        submit_word();
        submit_word();           // Empty word

        test_name = "random_words";
        for (int w = 0; w < 4; w++) begin
            n_letters = (w == 0) ? 11 : int'(rand_below(12));  // First one overflows
            for (int l = 0; l < n_letters; l++) begin
                idx  = rand_below(8);
                taps = 1 + rand_below(5);
                enter_letter(idx, taps);
            end
            submit_word();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: keypad_top.f
rtl/keypad_pkg.sv
rtl/key_scanner.sv
rtl/keypad_fsm.sv
rtl/word_buffer.sv
rtl/keypad_top.sv
dv/keypad_tb.sv

// File: Bender.yml
package:
  name: keypad_top

sources:
  # Package first, then the chain bottom up
  - rtl/keypad_pkg.sv
  - rtl/key_scanner.sv
  - rtl/keypad_fsm.sv
  - rtl/word_buffer.sv
  - rtl/keypad_top.sv
  - target: test
    files:
      - dv/keypad_tb.sv
